// File: vlog.f
+incdir+logic
logic/pcore_isa_pkg.sv
logic/pcore_pipe_pkg.sv
logic/id_decode.sv
logic/exe_alu.sv
logic/lsu_mem.sv
logic/forward_stall.sv
logic/wrb_regfile.sv
logic/pcore_top.sv
verification/pcore_sva.sv
verification/pcore_tb.sv

// File: verification/pcore_stimulus.txt
# T <test name> | I <instruction word, hex> | W <rd, decimal> <expected data, hex>
# W lines list the register writes of all I lines in program order
T alu_basic
I 00500093 # addi x1, x0, 5
I 00C00113 # addi x2, x0, 12
I FF900193 # addi x3, x0, -7
I 00208233 # add  x4, x1, x2
I 403102B3 # sub  x5, x2, x3
I 06418313 # addi x6, x3, 100
W 1 00000005
W 2 0000000C
W 3 FFFFFFF9
W 4 00000011
W 5 00000013
W 6 0000005D
T fwd_chain
I 00100393 # addi x7, x0, 1
I 00738433 # add  x8, x7, x7
I 007404B3 # add  x9, x8, x7
I 40848533 # sub  x10, x9, x8
I 009505B3 # add  x11, x10, x9
W 7 00000001
W 8 00000002
W 9 00000003
W 10 00000001
W 11 00000004
T store_load
I 04000613 # addi x12, x0, 64
I 00462423 # sw   x4, 8(x12)
I 00862683 # lw   x13, 8(x12)
I 00C62703 # lw   x14, 12(x12), never written
W 12 00000040
W 13 00000011
W 14 00000000
T load_use
I 00562023 # sw   x5, 0(x12)
I 00062783 # lw   x15, 0(x12)
I 00178833 # add  x16, x15, x1
I 00862883 # lw   x17, 8(x12)
I 41130933 # sub  x18, x6, x17
W 15 00000013
W 16 00000018
W 17 00000011
W 18 0000004C
T x0_and_nop
I 03700013 # addi x0, x0, 55
I 00208033 # add  x0, x1, x2
I 00209233 # sll  x4, x1, x2, unsupported
I FFFFFFFF # unknown opcode
I 000209B3 # add  x19, x4, x0
W 19 00000011
T mixed_stalls
I 00062A83 # lw   x21, 0(x12)
I 00862B03 # lw   x22, 8(x12)
I 016A8BB3 # add  x23, x21, x22
I 01762223 # sw   x23, 4(x12)
I 00462C03 # lw   x24, 4(x12)
I 407C0CB3 # sub  x25, x24, x7
W 21 00000013
W 22 00000011
W 23 00000024
W 24 00000024
W 25 00000023

// File: verification/pcore_tb.sv
// Pipeline slice testbench
module pcore_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int STALL_LIMIT  = 20;
    localparam int DONE_LIMIT   = 200;
    localparam int DRAIN_CYCLES = 12;

    logic                     clk;
    logic                     rst_n;
    pcore_isa_pkg::instr_t    instr_i;
    logic                     instr_valid_i;
    logic                     if_stall_o;
    logic                     wrb_valid_o;
    pcore_isa_pkg::reg_addr_t wrb_rd_o;
    pcore_isa_pkg::word_t     wrb_data_o;

    pcore_isa_pkg::instr_t    instr_q[$];
    pcore_isa_pkg::reg_addr_t exp_rd_q[$];
    pcore_isa_pkg::word_t     exp_data_q[$];
    string                    exp_test_q[$];
    int                       checked;

    pcore_top pcore_top_inst (
        .clk(clk), .rst_n(rst_n), .instr_i(instr_i), .instr_valid_i(instr_valid_i),
        .if_stall_o(if_stall_o), .wrb_valid_o(wrb_valid_o),
        .wrb_rd_o(wrb_rd_o), .wrb_data_o(wrb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string test_name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED test %s %s expected %h actual %h",
                     test_name, field, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "Run aborted");
    endtask

    // Parses T, I and W lines and ignores text after the fields
    task automatic load_stimulus();
        int          fd;
        int          n;
        int          rd;
        string       line;
        string       cur_test;
        logic [31:0] value;
        fd = $fopen("verification/pcore_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the stimulus file verification/pcore_stimulus.txt");
        end else begin
            cur_test = "unnamed";
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#") begin
                    case (line.getc(0))
                        "T": begin
                            n = $sscanf(line, "T %s", cur_test);
                            if (n != 1) begin
                                abort_run({"Malformed line in stimulus file: ", line});
                            end
                        end
                        "I": begin
                            n = $sscanf(line, "I %h", value);
                            if (n != 1) begin
                                abort_run({"Malformed line in stimulus file: ", line});
                            end
                            instr_q.push_back(value);
                        end
                        "W": begin
                            n = $sscanf(line, "W %d %h", rd, value);
                            if (n != 2) begin
                                abort_run({"Malformed line in stimulus file: ", line});
                            end
                            exp_rd_q.push_back(pcore_isa_pkg::reg_addr_t'(rd));
                            exp_data_q.push_back(value);
                            exp_test_q.push_back(cur_test);
                        end
                        default: abort_run({"Unknown line in stimulus file: ", line});
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic idle_cycles(input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            #2;
        end
    endtask

    // Holds the word until an edge where the front end is not stalled
    task automatic send_instr(input pcore_isa_pkg::instr_t word);
        int waited;
        waited        = 0;
        instr_i       = word;
        instr_valid_i = 1'b1;
        @(negedge clk);
        while (if_stall_o) begin
            waited++;
            if (waited > STALL_LIMIT) begin
                abort_run("Timeout: if_stall_o held an instruction for too long");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        instr_valid_i = 1'b0;
    endtask

    // Outputs are stable at the falling edge, so writebacks are compared there
    always @(negedge clk) begin
        if (rst_n && wrb_valid_o) begin
            if (exp_rd_q.size() == 0) begin
                abort_run($sformatf("Unexpected extra writeback to x%0d", wrb_rd_o));
            end else begin
                check_value(exp_test_q[0], "rd", 32'(exp_rd_q[0]), 32'(wrb_rd_o));
                check_value(exp_test_q[0], "data", exp_data_q[0], wrb_data_o);
                exp_rd_q.delete(0);
                exp_data_q.delete(0);
                exp_test_q.delete(0);
                checked++;
            end
        end
    end

    initial begin
        int gap;
        int waited;
        rst_n         = 1'b0;
        instr_i       = '0;
        instr_valid_i = 1'b0;
        checked       = 0;
        void'($urandom(32'h64a5_274f));
        load_stimulus();
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        foreach (instr_q[i]) begin
            gap = $urandom_range(2, 0);
            idle_cycles(gap);
            send_instr(instr_q[i]);
        end
        waited = 0;
        while (exp_rd_q.size() != 0) begin
            waited++;
            if (waited > DONE_LIMIT) begin
                abort_run($sformatf("Timeout: %0d expected writebacks never arrived",
                                    exp_rd_q.size()));
            end
            @(negedge clk);
        end
        // Let the pipeline empty so that a late extra write is caught
        for (int i = 0; i < DRAIN_CYCLES; i++) begin
            @(posedge clk);
        end
        $display("%0d writebacks matched", checked);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: verification/pcore_sva.sv
// Pipeline slice assertions
`include "pcore_consts.svh"

module pcore_sva (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     if_stall_i,
    input logic                     wrb_valid_i,
    input pcore_isa_pkg::reg_addr_t wrb_rd_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // x0 is hardwired, so it never shows up on the report port
    no_x0_write: assert property (
        @(posedge clk) disable iff (!rst_n) wrb_valid_i |-> (wrb_rd_i != '0)
    ) else $error("Writeback reported for register x0");

    stall_low_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> !if_stall_i
    ) else $error("if_stall_o high in the first cycle after reset release");

    // Load-use stall over a full memory access is the longest hold
    stall_bounded: assert property (
        @(posedge clk) disable iff (!rst_n)
        if_stall_i |-> ##[1:(`PCORE_MEM_LAT + 3)] !if_stall_i
    ) else $error("if_stall_o held longer than %0d cycles", `PCORE_MEM_LAT + 3);

endmodule

bind pcore_top pcore_sva pcore_sva_inst (
    .clk(clk),
    .rst_n(rst_n),
    .if_stall_i(if_stall_o),
    .wrb_valid_i(wrb_valid_o),
    .wrb_rd_i(wrb_rd_o)
);

// File: logic/pcore_top.sv
// Pipeline slice top level
module pcore_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  pcore_isa_pkg::instr_t    instr_i,
    input  logic                     instr_valid_i,
    output logic                     if_stall_o,
    output logic                     wrb_valid_o,
    output pcore_isa_pkg::reg_addr_t wrb_rd_o,
    output pcore_isa_pkg::word_t     wrb_data_o
);

    pcore_isa_pkg::reg_addr_t  rs1_addr;
    pcore_isa_pkg::reg_addr_t  rs2_addr;
    pcore_isa_pkg::word_t      rs1_data;
    pcore_isa_pkg::word_t      rs2_data;
    pcore_isa_pkg::word_t      wrb_fwd_data;
    pcore_pipe_pkg::id2exe_s   id2exe;
    pcore_pipe_pkg::exe2lsu_s  exe2lsu;
    pcore_pipe_pkg::lsu2wrb_s  lsu2wrb;
    pcore_pipe_pkg::exe2fwd_s  exe2fwd;
    pcore_pipe_pkg::lsu2fwd_s  lsu2fwd;
    pcore_pipe_pkg::wrb2fwd_s  wrb2fwd;
    pcore_pipe_pkg::fwd2exe_s  fwd2exe;
    pcore_pipe_pkg::fwd2pipe_s fwd2pipe;

    id_decode id_decode_inst (
        .clk(clk), .rst_n(rst_n), .instr_i(instr_i), .instr_valid_i(instr_valid_i),
        .rf_rs1_addr_o(rs1_addr), .rf_rs2_addr_o(rs2_addr),
        .rf_rs1_data_i(rs1_data), .rf_rs2_data_i(rs2_data),
        .fwd2pipe_i(fwd2pipe), .id2exe_o(id2exe)
    );

    exe_alu exe_alu_inst (
        .clk(clk), .rst_n(rst_n), .id2exe_i(id2exe), .fwd2exe_i(fwd2exe),
        .lsu_fwd_data_i(exe2lsu.result), .wrb_fwd_data_i(wrb_fwd_data),
        .fwd2pipe_i(fwd2pipe), .exe2fwd_o(exe2fwd), .exe2lsu_o(exe2lsu)
    );

    lsu_mem lsu_mem_inst (
        .clk(clk), .rst_n(rst_n), .exe2lsu_i(exe2lsu),
        .lsu2fwd_o(lsu2fwd), .lsu2wrb_o(lsu2wrb)
    );

    wrb_regfile wrb_regfile_inst (
        .clk(clk), .rst_n(rst_n), .lsu2wrb_i(lsu2wrb),
        .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .wrb2fwd_o(wrb2fwd), .wrb_fwd_data_o(wrb_fwd_data),
        .wrb_valid_o(wrb_valid_o), .wrb_rd_o(wrb_rd_o), .wrb_data_o(wrb_data_o)
    );

    forward_stall forward_stall_inst (
        .clk(clk), .rst_n(rst_n), .exe2fwd_i(exe2fwd), .lsu2fwd_i(lsu2fwd),
        .wrb2fwd_i(wrb2fwd), .fwd2exe_o(fwd2exe), .fwd2pipe_o(fwd2pipe),
        .if_stall_o(if_stall_o)
    );

endmodule

// File: logic/wrb_regfile.sv
// Register file and writeback
module wrb_regfile (
    input  logic                     clk,
    input  logic                     rst_n,
    input  pcore_pipe_pkg::lsu2wrb_s lsu2wrb_i,
    input  pcore_isa_pkg::reg_addr_t rs1_addr_i,
    input  pcore_isa_pkg::reg_addr_t rs2_addr_i,
    output pcore_isa_pkg::word_t     rs1_data_o,
    output pcore_isa_pkg::word_t     rs2_data_o,
    output pcore_pipe_pkg::wrb2fwd_s wrb2fwd_o,
    output pcore_isa_pkg::word_t     wrb_fwd_data_o,
    output logic                     wrb_valid_o,
    output pcore_isa_pkg::reg_addr_t wrb_rd_o,
    output pcore_isa_pkg::word_t     wrb_data_o
);

    pcore_isa_pkg::word_t regs [1:31];
    logic                 wr_en;

    assign wr_en = lsu2wrb_i.valid & lsu2wrb_i.rd_wr_req & (|lsu2wrb_i.rd_addr);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (wr_en) begin
            regs[lsu2wrb_i.rd_addr] <= lsu2wrb_i.data;
        end
    end

    // Write-first reads, x0 hardwired to zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0
                      : (wr_en && rs1_addr_i == lsu2wrb_i.rd_addr) ? lsu2wrb_i.data
                      : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0
                      : (wr_en && rs2_addr_i == lsu2wrb_i.rd_addr) ? lsu2wrb_i.data
                      : regs[rs2_addr_i];

    assign wrb2fwd_o.rd_addr   = lsu2wrb_i.rd_addr;
    assign wrb2fwd_o.rd_wr_req = lsu2wrb_i.valid & lsu2wrb_i.rd_wr_req;
    assign wrb_fwd_data_o      = lsu2wrb_i.data;

    assign wrb_valid_o = wr_en;
    assign wrb_rd_o    = lsu2wrb_i.rd_addr;
    assign wrb_data_o  = lsu2wrb_i.data;

endmodule

// File: logic/forward_stall.sv
// Hazard detection and forwarding
module forward_stall (
    input  logic                      clk,
    input  logic                      rst_n,
    input  pcore_pipe_pkg::exe2fwd_s  exe2fwd_i,
    input  pcore_pipe_pkg::lsu2fwd_s  lsu2fwd_i,
    input  pcore_pipe_pkg::wrb2fwd_s  wrb2fwd_i,
    output pcore_pipe_pkg::fwd2exe_s  fwd2exe_o,
    output pcore_pipe_pkg::fwd2pipe_s fwd2pipe_o,
    output logic                      if_stall_o
);

    logic rs1_valid;
    logic rs2_valid;
    logic lsu_rs1_hazard;
    logic lsu_rs2_hazard;
    logic ld_use_hazard;
    logic mem_stall_q;
    logic mem_stall_next;
    logic front_stall;

    // x0 never creates a dependency
    assign rs1_valid = |exe2fwd_i.rs1_addr;
    assign rs2_valid = |exe2fwd_i.rs2_addr;

    assign lsu_rs1_hazard = rs1_valid & lsu2fwd_i.rd_wr_req
                          & (exe2fwd_i.rs1_addr == lsu2fwd_i.rd_addr);
    assign lsu_rs2_hazard = rs2_valid & lsu2fwd_i.rd_wr_req
                          & (exe2fwd_i.rs2_addr == lsu2fwd_i.rd_addr);

    // A load result is not ready in the load/store stage
    assign fwd2exe_o.fwd_lsu_rs1 = lsu_rs1_hazard & ~lsu2fwd_i.lsu_req;
    assign fwd2exe_o.fwd_lsu_rs2 = lsu_rs2_hazard & ~lsu2fwd_i.lsu_req;

    assign fwd2exe_o.fwd_wrb_rs1 = rs1_valid & wrb2fwd_i.rd_wr_req
                                 & (exe2fwd_i.rs1_addr == wrb2fwd_i.rd_addr);
    assign fwd2exe_o.fwd_wrb_rs2 = rs2_valid & wrb2fwd_i.rd_wr_req
                                 & (exe2fwd_i.rs2_addr == wrb2fwd_i.rd_addr);

    assign ld_use_hazard = lsu2fwd_i.lsu_req
                         & ((lsu_rs1_hazard & exe2fwd_i.use_rs1)
                         |  (lsu_rs2_hazard & exe2fwd_i.use_rs2));

    // Memory stall level, set by request and cleared by acknowledge
    always_comb begin
        mem_stall_next = mem_stall_q;
        if (lsu2fwd_i.lsu_ack) begin
            mem_stall_next = 1'b0;
        end else if (lsu2fwd_i.lsu_req) begin
            mem_stall_next = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_stall_q <= 1'b0;
        end else begin
            mem_stall_q <= mem_stall_next;
        end
    end

    assign front_stall = ld_use_hazard | mem_stall_next;

    assign fwd2pipe_o.id2exe_stall  = front_stall;
    assign fwd2pipe_o.exe2lsu_stall = mem_stall_next;
    // Bubble only once the load has been acknowledged and moves on
    assign fwd2pipe_o.exe2lsu_flush = ld_use_hazard & ~mem_stall_next;

    assign if_stall_o = front_stall;

endmodule

// File: logic/lsu_mem.sv
// Load/store stage and data memory
`include "pcore_consts.svh"

module lsu_mem (
    input  logic                     clk,
    input  logic                     rst_n,
    input  pcore_pipe_pkg::exe2lsu_s exe2lsu_i,
    output pcore_pipe_pkg::lsu2fwd_s lsu2fwd_o,
    output pcore_pipe_pkg::lsu2wrb_s lsu2wrb_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_ACK
    } lsu_state_e;

    lsu_state_e                                 state_q;
    logic [$clog2(`PCORE_MEM_LAT+1)-1:0]        cnt_q;
    pcore_isa_pkg::word_t                       dmem [2**`PCORE_DMEM_AW];
    pcore_isa_pkg::dmem_addr_t                  addr;
    logic                                       mem_op;
    logic                                       ack;
    pcore_pipe_pkg::lsu2wrb_s                   lsu2wrb_q;

    assign mem_op = exe2lsu_i.valid & (exe2lsu_i.is_load | exe2lsu_i.is_store);
    assign ack    = (state_q == S_ACK);
    assign addr   = exe2lsu_i.result[`PCORE_DMEM_AW+1:2];

    // Access timer, acknowledges after the fixed memory latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (mem_op) begin
                        state_q <= (`PCORE_MEM_LAT > 1) ? S_WAIT : S_ACK;
                        cnt_q   <= 1;
                    end
                end
                S_WAIT: begin
                    if (cnt_q >= `PCORE_MEM_LAT - 1) begin
                        state_q <= S_ACK;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // Unwritten words must read as zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dmem <= '{default: '0};
        end else if (ack && exe2lsu_i.is_store) begin
            dmem[addr] <= exe2lsu_i.store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lsu2wrb_q.valid     <= 1'b0;
            lsu2wrb_q.rd_wr_req <= 1'b0;
        end else if (mem_op && !ack) begin
            lsu2wrb_q.valid     <= 1'b0;
            lsu2wrb_q.rd_wr_req <= 1'b0;
        end else begin
            lsu2wrb_q.valid     <= exe2lsu_i.valid;
            lsu2wrb_q.rd_addr   <= exe2lsu_i.rd_addr;
            lsu2wrb_q.rd_wr_req <= exe2lsu_i.rd_wr_req;
            lsu2wrb_q.data      <= exe2lsu_i.is_load ? dmem[addr] : exe2lsu_i.result;
        end
    end

    // Request covers the whole stay of the access, acknowledge cycle included
    assign lsu2fwd_o.rd_addr   = exe2lsu_i.rd_addr;
    assign lsu2fwd_o.rd_wr_req = exe2lsu_i.rd_wr_req;
    assign lsu2fwd_o.lsu_req   = mem_op;
    assign lsu2fwd_o.lsu_ack   = ack;

    assign lsu2wrb_o = lsu2wrb_q;

endmodule

// File: logic/exe_alu.sv
// Execute stage with forwarding
module exe_alu (
    input  logic                      clk,
    input  logic                      rst_n,
    input  pcore_pipe_pkg::id2exe_s   id2exe_i,
    input  pcore_pipe_pkg::fwd2exe_s  fwd2exe_i,
    input  pcore_isa_pkg::word_t      lsu_fwd_data_i,
    input  pcore_isa_pkg::word_t      wrb_fwd_data_i,
    input  pcore_pipe_pkg::fwd2pipe_s fwd2pipe_i,
    output pcore_pipe_pkg::exe2fwd_s  exe2fwd_o,
    output pcore_pipe_pkg::exe2lsu_s  exe2lsu_o
);

    pcore_isa_pkg::word_t     rs1_val;
    pcore_isa_pkg::word_t     rs2_val;
    pcore_isa_pkg::word_t     opnd_b;
    pcore_isa_pkg::word_t     result;
    pcore_pipe_pkg::exe2lsu_s exe2lsu_q;

    // Load/store stage data is the younger value and wins
    always_comb begin
        if (fwd2exe_i.fwd_lsu_rs1) begin
            rs1_val = lsu_fwd_data_i;
        end else if (fwd2exe_i.fwd_wrb_rs1) begin
            rs1_val = wrb_fwd_data_i;
        end else begin
            rs1_val = id2exe_i.rs1_data;
        end
        if (fwd2exe_i.fwd_lsu_rs2) begin
            rs2_val = lsu_fwd_data_i;
        end else if (fwd2exe_i.fwd_wrb_rs2) begin
            rs2_val = wrb_fwd_data_i;
        end else begin
            rs2_val = id2exe_i.rs2_data;
        end
    end

    // Stores take rs2 as data, so their second operand is the offset
    assign opnd_b = (id2exe_i.use_rs2 && !id2exe_i.is_store) ? rs2_val : id2exe_i.imm;
    assign result = (id2exe_i.alu_op == pcore_isa_pkg::ALU_SUB) ? rs1_val - opnd_b
                                                                : rs1_val + opnd_b;

    assign exe2fwd_o.rs1_addr = id2exe_i.rs1_addr;
    assign exe2fwd_o.rs2_addr = id2exe_i.rs2_addr;
    assign exe2fwd_o.use_rs1  = id2exe_i.use_rs1;
    assign exe2fwd_o.use_rs2  = id2exe_i.use_rs2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exe2lsu_q.valid     <= 1'b0;
            exe2lsu_q.rd_wr_req <= 1'b0;
            exe2lsu_q.is_load   <= 1'b0;
            exe2lsu_q.is_store  <= 1'b0;
        end else if (!fwd2pipe_i.exe2lsu_stall) begin
            if (fwd2pipe_i.exe2lsu_flush) begin
                // Bubble behind a load that is still in flight
                exe2lsu_q.valid     <= 1'b0;
                exe2lsu_q.rd_wr_req <= 1'b0;
                exe2lsu_q.is_load   <= 1'b0;
                exe2lsu_q.is_store  <= 1'b0;
            end else begin
                exe2lsu_q.valid      <= id2exe_i.valid;
                exe2lsu_q.rd_addr    <= id2exe_i.rd_addr;
                exe2lsu_q.rd_wr_req  <= id2exe_i.rd_wr_req;
                exe2lsu_q.is_load    <= id2exe_i.is_load;
                exe2lsu_q.is_store   <= id2exe_i.is_store;
                exe2lsu_q.result     <= result;
                exe2lsu_q.store_data <= rs2_val;
            end
        end
    end

    assign exe2lsu_o = exe2lsu_q;

endmodule

// File: logic/id_decode.sv
// Instruction decode stage
module id_decode (
    input  logic                      clk,
    input  logic                      rst_n,
    input  pcore_isa_pkg::instr_t     instr_i,
    input  logic                      instr_valid_i,
    output pcore_isa_pkg::reg_addr_t  rf_rs1_addr_o,
    output pcore_isa_pkg::reg_addr_t  rf_rs2_addr_o,
    input  pcore_isa_pkg::word_t      rf_rs1_data_i,
    input  pcore_isa_pkg::word_t      rf_rs2_data_i,
    input  pcore_pipe_pkg::fwd2pipe_s fwd2pipe_i,
    output pcore_pipe_pkg::id2exe_s   id2exe_o
);

    pcore_isa_pkg::instr_t   ir_q;
    logic                    ir_valid_q;
    logic                    stall;
    pcore_pipe_pkg::id2exe_s dec;
    pcore_pipe_pkg::id2exe_s id2exe_q;

    assign stall = fwd2pipe_i.id2exe_stall;

    // Instruction register, held with the rest of the front end
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir_valid_q <= 1'b0;
        end else if (!stall) begin
            ir_valid_q <= instr_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ir_q <= instr_i;
        end
    end

    // While held, the read ports refetch the operands of the waiting
    // execute instruction so that writes retiring beneath it are picked up
    assign rf_rs1_addr_o = stall ? id2exe_q.rs1_addr : ir_q[19:15];
    assign rf_rs2_addr_o = stall ? id2exe_q.rs2_addr : ir_q[24:20];

    always_comb begin
        dec          = '0;
        dec.alu_op   = pcore_isa_pkg::ALU_ADD;
        dec.rs1_addr = ir_q[19:15];
        dec.rs2_addr = ir_q[24:20];
        dec.rd_addr  = ir_q[11:7];
        dec.rs1_data = rf_rs1_data_i;
        dec.rs2_data = rf_rs2_data_i;
        dec.imm      = pcore_isa_pkg::word_t'($signed(ir_q[31:20]));
        if (ir_valid_q) begin
            case (pcore_isa_pkg::opcode_e'(ir_q[6:0]))
                pcore_isa_pkg::OPC_OP: begin
                    if (ir_q[14:12] == 3'b000 && ir_q[31:25] inside {7'h00, 7'h20}) begin
                        dec.valid     = 1'b1;
                        dec.use_rs1   = 1'b1;
                        dec.use_rs2   = 1'b1;
                        dec.rd_wr_req = 1'b1;
                        dec.alu_op    = ir_q[30] ? pcore_isa_pkg::ALU_SUB
                                                 : pcore_isa_pkg::ALU_ADD;
                    end
                end
                pcore_isa_pkg::OPC_OP_IMM: begin
                    if (ir_q[14:12] == 3'b000) begin
                        dec.valid     = 1'b1;
                        dec.use_rs1   = 1'b1;
                        dec.rd_wr_req = 1'b1;
                    end
                end
                pcore_isa_pkg::OPC_LOAD: begin
                    // Word loads only
                    if (ir_q[14:12] == 3'b010) begin
                        dec.valid     = 1'b1;
                        dec.use_rs1   = 1'b1;
                        dec.rd_wr_req = 1'b1;
                        dec.is_load   = 1'b1;
                    end
                end
                pcore_isa_pkg::OPC_STORE: begin
                    if (ir_q[14:12] == 3'b010) begin
                        dec.valid    = 1'b1;
                        dec.use_rs1  = 1'b1;
                        dec.use_rs2  = 1'b1;
                        dec.is_store = 1'b1;
                        dec.imm      = pcore_isa_pkg::word_t'(
                                           $signed({ir_q[31:25], ir_q[11:7]}));
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id2exe_q.valid     <= 1'b0;
            id2exe_q.use_rs1   <= 1'b0;
            id2exe_q.use_rs2   <= 1'b0;
            id2exe_q.rd_wr_req <= 1'b0;
            id2exe_q.is_load   <= 1'b0;
            id2exe_q.is_store  <= 1'b0;
        end else if (!stall) begin
            id2exe_q <= dec;
        end else begin
            id2exe_q.rs1_data <= rf_rs1_data_i;
            id2exe_q.rs2_data <= rf_rs2_data_i;
        end
    end

    assign id2exe_o = id2exe_q;

endmodule

// File: logic/pcore_pipe_pkg.sv
// Pipeline and hazard structs
package pcore_pipe_pkg;

    typedef struct packed {
        logic                     valid;
        pcore_isa_pkg::alu_op_e   alu_op;
        pcore_isa_pkg::reg_addr_t rs1_addr;
        pcore_isa_pkg::reg_addr_t rs2_addr;
        logic                     use_rs1;
        logic                     use_rs2;
        pcore_isa_pkg::word_t     rs1_data;
        pcore_isa_pkg::word_t     rs2_data;
        pcore_isa_pkg::word_t     imm;
        pcore_isa_pkg::reg_addr_t rd_addr;
        logic                     rd_wr_req;
        logic                     is_load;
        logic                     is_store;
    } id2exe_s;

    typedef struct packed {
        logic                     valid;
        pcore_isa_pkg::reg_addr_t rd_addr;
        logic                     rd_wr_req;
        logic                     is_load;
        logic                     is_store;
        // Also the memory address for loads and stores
        pcore_isa_pkg::word_t     result;
        pcore_isa_pkg::word_t     store_data;
    } exe2lsu_s;

    typedef struct packed {
        logic                     valid;
        pcore_isa_pkg::reg_addr_t rd_addr;
        logic                     rd_wr_req;
        pcore_isa_pkg::word_t     data;
    } lsu2wrb_s;

    typedef struct packed {
        pcore_isa_pkg::reg_addr_t rs1_addr;
        pcore_isa_pkg::reg_addr_t rs2_addr;
        logic                     use_rs1;
        logic                     use_rs2;
    } exe2fwd_s;

    typedef struct packed {
        pcore_isa_pkg::reg_addr_t rd_addr;
        logic                     rd_wr_req;
        logic                     lsu_req;
        logic                     lsu_ack;
    } lsu2fwd_s;

    typedef struct packed {
        pcore_isa_pkg::reg_addr_t rd_addr;
        logic                     rd_wr_req;
    } wrb2fwd_s;

    typedef struct packed {
        logic fwd_lsu_rs1;
        logic fwd_lsu_rs2;
        logic fwd_wrb_rs1;
        logic fwd_wrb_rs2;
    } fwd2exe_s;

    typedef struct packed {
        logic id2exe_stall;
        logic exe2lsu_stall;
        logic exe2lsu_flush;
    } fwd2pipe_s;

endpackage

// File: logic/pcore_isa_pkg.sv
// Instruction set types
`include "pcore_consts.svh"

package pcore_isa_pkg;

    typedef logic [`PCORE_XLEN-1:0] word_t;
    typedef logic [`PCORE_REG_AW-1:0] reg_addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [`PCORE_DMEM_AW-1:0] dmem_addr_t;

    // RV32I major opcodes handled by the slice
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic {
        ALU_ADD = 1'b0,
        ALU_SUB = 1'b1
    } alu_op_e;

endpackage

// File: logic/pcore_consts.svh
// Pipeline slice constants
`ifndef PCORE_CONSTS_SVH
`define PCORE_CONSTS_SVH

// Data word width
`define PCORE_XLEN 32

// Register file index width
`define PCORE_REG_AW 5

// Data memory word-address width, 64 words
`define PCORE_DMEM_AW 6

// Cycles from a load/store request to its acknowledge
`define PCORE_MEM_LAT 2

`endif
